// File: source/petPkg.sv
package petPkg;
	localparam int lifeCountWidth = 9;
	localparam int ageWidth = 4;
	localparam int maxLifeSpan = 330;
	localparam int neglectLimit = 7;
	localparam int dyingLimit = 7;
	localparam int sleepLimit = 12;

	// schedules in life seconds, every period is a power of two
	localparam int hungerPeriod = 16;
	localparam int hungerPhase = 15;
	localparam int boredPeriod = 32;
	localparam int boredPhase = 19;
	localparam int dirtyPeriod = 32;
	localparam int dirtyPhase = 24;
	localparam int sickPeriod = 32;
	localparam int sickPhase = 29;
	localparam int neglectPeriod = 4;
	localparam int neglectPhase = 2;
	localparam int sickNeglectPhase = 3; // sickness lags the others by one second
	localparam int sleepPeriod = 64;
	localparam int sleepPhase = 44;
	localparam int sleepStepPeriod = 8;
	localparam int sleepStepPhase = 4;
	localparam int dyingStepPeriod = 32;
	localparam int dyingStepPhase = 28;

	typedef enum logic [1:0] {HUNGER, BOREDOM, DIRTINESS, SICKNESS} needKind;

	typedef enum logic [2:0] {FEED, PLAY, CLEAN, MEDICATE, FIRST_AID, RESTART} careOp;

	typedef enum logic [1:0] {AWAKE, ASLEEP, DYING, DECEASED} lifeState;

	typedef struct packed {
		logic valid;
		careOp op;
	} careCmd;

	typedef struct packed {
		logic hungry;
		logic bored;
		logic dirty;
		logic sick;
		logic sleeping;
		logic dying;
		logic deceased;
		logic [ageWidth-1:0] age;
		logic [lifeCountWidth-1:0] lifeCount;
	} petStatus;

	// true when count sits at phase within a power-of-two period
	function automatic logic onSchedule(input logic [lifeCountWidth-1:0] count,
			input int period, input int phase);
		onSchedule = (count & lifeCountWidth'(period - 1)) == lifeCountWidth'(phase);
	endfunction
endpackage

// File: source/busPkg.sv
package busPkg;
	localparam int addrWidth = 4;
	localparam int dataWidth = 32;

	localparam logic [addrWidth-1:0] careAddr = 4'h0; // write only
	localparam logic [addrWidth-1:0] statusAddr = 4'h4;
	localparam logic [addrWidth-1:0] ageAddr = 4'h8;
	localparam logic [addrWidth-1:0] lifeAddr = 4'hC;

	typedef enum logic [1:0] {
		OKAY = 2'b00,
		SLVERR = 2'b10
	} axiResp;

	// host to slave, single outstanding, no strobes or prot
	typedef struct packed {
		logic awvalid;
		logic [addrWidth-1:0] awaddr;
		logic wvalid;
		logic [dataWidth-1:0] wdata;
		logic bready;
		logic arvalid;
		logic [addrWidth-1:0] araddr;
		logic rready;
	} axiReq;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		axiResp bresp;
		logic arready;
		logic rvalid;
		logic [dataWidth-1:0] rdata;
		axiResp rresp;
	} axiRsp;
endpackage

// File: source/lifeTimer.sv
module lifeTimer #(
	parameter int ticksPerSecond = 50000000
) (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic running,
	output logic tick,
	output logic [petPkg::lifeCountWidth-1:0] lifeCount,
	output logic expired
);
	import petPkg::*;

	logic [$clog2(ticksPerSecond + 1)-1:0] cycleCount;
	logic counting;

	assign expired = lifeCount == lifeCountWidth'(maxLifeSpan);
	assign counting = running && !expired; // life stops at the span or at death

	// one pulse per pet second, on the last cycle of the second
	assign tick = counting && cycleCount == $bits(cycleCount)'(ticksPerSecond - 1);

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			cycleCount <= '0;
			lifeCount <= '0;
		end
		else if (counting) begin
			if (tick) begin
				cycleCount <= '0;
				lifeCount <= lifeCount + 1'b1;
			end
			else begin
				cycleCount <= cycleCount + 1'b1;
			end
		end
	end

endmodule

// File: source/needTracker.sv
module needTracker #(
	parameter petPkg::needKind kind = petPkg::HUNGER
) (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic tick,
	input logic [petPkg::lifeCountWidth-1:0] lifeCount,
	input logic needsRunning,
	input petPkg::careCmd care,
	output logic needy,
	output logic neglected
);
	import petPkg::*;

	logic [lifeCountWidth-1:0] nextCount;
	logic [2:0] neglectCount;
	logic onsetDue;
	logic stepDue;
	logic cured;
	logic aided;
	logic stepping;
	careOp cureOp;

	// schedules look at the second the tick is about to enter
	assign nextCount = lifeCount + 1'b1;

	always_comb begin
		stepDue = onSchedule(nextCount, neglectPeriod, neglectPhase);
		case (kind)
			HUNGER: begin
				cureOp = FEED;
				onsetDue = onSchedule(nextCount, hungerPeriod, hungerPhase);
			end
			BOREDOM: begin
				cureOp = PLAY;
				onsetDue = onSchedule(nextCount, boredPeriod, boredPhase);
			end
			DIRTINESS: begin
				cureOp = CLEAN;
				onsetDue = onSchedule(nextCount, dirtyPeriod, dirtyPhase);
			end
			default: begin
				cureOp = MEDICATE;
				onsetDue = onSchedule(nextCount, sickPeriod, sickPhase);
				stepDue = onSchedule(nextCount, neglectPeriod, sickNeglectPhase);
			end
		endcase
	end

	assign cured = care.valid && care.op == cureOp;
	assign aided = care.valid && care.op == FIRST_AID;
	assign stepping = tick && needsRunning && needy && stepDue && !cured && !aided;

	// combinational so the pet turns dying on the same edge as the last step
	assign neglected = stepping && neglectCount == 3'(neglectLimit - 1);

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			needy <= 1'b0;
			neglectCount <= '0;
		end
		else if (cured) begin
			needy <= 1'b0;
			neglectCount <= '0;
		end
		else if (aided) begin
			neglectCount <= '0; // flag stays, only the countdown restarts
		end
		else if (tick && needsRunning && !needy) begin
			needy <= onsetDue;
		end
		else if (stepping) begin
			neglectCount <= neglectCount + 1'b1;
		end
	end

endmodule

// File: source/petVitality.sv
module petVitality (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic [petPkg::lifeCountWidth-1:0] lifeCount,
	input logic expired,
	input logic neglectedAny,
	input petPkg::careCmd care,
	output petPkg::lifeState state,
	output logic [petPkg::ageWidth-1:0] age,
	output logic needsRunning,
	output logic clear,
	output logic running
);
	import petPkg::*;

	lifeState nextState;
	logic [lifeCountWidth-1:0] nextCount;
	logic [3:0] sleepCount;
	logic [2:0] dyingCount;
	logic restart;
	logic aided;
	logic sleepDue;
	logic sleepStep;
	logic dyingStep;

	assign nextCount = lifeCount + 1'b1;
	assign restart = care.valid && care.op == RESTART;
	assign aided = care.valid && care.op == FIRST_AID;

	assign sleepDue = tick && onSchedule(nextCount, sleepPeriod, sleepPhase);
	assign sleepStep = tick && onSchedule(nextCount, sleepStepPeriod, sleepStepPhase);
	assign dyingStep = tick && onSchedule(nextCount, dyingStepPeriod, dyingStepPhase);

	always_comb begin
		nextState = state;
		case (state)
			AWAKE: begin
				if (neglectedAny)
					nextState = DYING;
				else if (sleepDue)
					nextState = ASLEEP;
			end
			ASLEEP: begin
				if (sleepStep && sleepCount == 4'(sleepLimit - 1))
					nextState = AWAKE;
			end
			DYING: begin
				if (aided)
					nextState = AWAKE;
				else if (dyingStep && dyingCount == 3'(dyingLimit - 1))
					nextState = DECEASED;
			end
			default: nextState = DECEASED;
		endcase
		if (expired)
			nextState = DECEASED; // out of life span
		if (restart)
			nextState = AWAKE;
	end

	// drops every need when the pet starts dying, dies, or the game restarts
	assign clear = restart
		|| (nextState != state && (nextState == DYING || nextState == DECEASED));

	assign needsRunning = state == AWAKE;
	assign running = state != DECEASED;

	always_ff @(posedge clk) begin
		if (reset || restart) begin
			state <= AWAKE;
			age <= '0;
			sleepCount <= '0;
			dyingCount <= '0;
		end
		else begin
			state <= nextState;
			if (state != ASLEEP)
				sleepCount <= '0;
			else if (sleepStep)
				sleepCount <= sleepCount + 1'b1;
			if (state == ASLEEP && nextState == AWAKE)
				age <= age + 1'b1; // a full night's sleep
			if (state != DYING)
				dyingCount <= '0;
			else if (dyingStep)
				dyingCount <= dyingCount + 1'b1;
		end
	end

endmodule

// File: source/careRegisters.sv
module careRegisters (
	input logic clk,
	input logic reset,
	input busPkg::axiReq bus,
	output busPkg::axiRsp busRsp,
	input petPkg::petStatus status,
	output petPkg::careCmd care
);
	import petPkg::*;
	import busPkg::*;

	logic bvalid;
	logic rvalid;
	axiResp bresp;
	axiResp rresp;
	logic [dataWidth-1:0] rdata;
	logic writeFire;
	logic readFire;
	axiResp writeResp;
	axiResp readResp;
	logic [dataWidth-1:0] readData;
	careOp writeOp;

	// address and data are taken together, only with no response waiting
	assign writeFire = bus.awvalid && bus.wvalid && !bvalid;
	assign readFire = bus.arvalid && !rvalid;
	assign writeOp = careOp'(bus.wdata[2:0]);

	always_comb begin
		writeResp = SLVERR;
		if (bus.awaddr == careAddr && bus.wdata[2:0] <= 3'(RESTART))
			writeResp = OKAY;
	end

	always_comb begin
		readResp = OKAY;
		readData = '0;
		case (bus.araddr)
			statusAddr: begin
				readData = dataWidth'({status.deceased, status.dying, status.sleeping,
					status.sick, status.dirty, status.bored, status.hungry});
			end
			ageAddr: readData = dataWidth'(status.age);
			lifeAddr: readData = dataWidth'(status.lifeCount);
			default: readResp = SLVERR; // care register and holes
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			care <= '0;
		end
		else begin
			care <= '{valid: writeFire && writeResp == OKAY, op: writeOp};
			if (writeFire)
				bvalid <= 1'b1;
			else if (bus.bready)
				bvalid <= 1'b0;
			if (readFire)
				rvalid <= 1'b1;
			else if (bus.rready)
				rvalid <= 1'b0;
		end
	end

	// response payload, captured at acceptance
	always_ff @(posedge clk) begin
		if (writeFire)
			bresp <= writeResp;
		if (readFire) begin
			rresp <= readResp;
			rdata <= readData;
		end
	end

	always_comb begin
		busRsp.awready = !bvalid;
		busRsp.wready = !bvalid;
		busRsp.bvalid = bvalid;
		busRsp.bresp = bresp;
		busRsp.arready = !rvalid;
		busRsp.rvalid = rvalid;
		busRsp.rdata = rdata;
		busRsp.rresp = rresp;
	end

endmodule

// File: source/petTop.sv
module petTop #(
	parameter int ticksPerSecond = 50000000
) (
	input logic clk,
	input logic reset,
	input busPkg::axiReq bus,
	output busPkg::axiRsp busRsp
);
	import petPkg::*;

	logic tick;
	logic expired;
	logic running;
	logic needsRunning;
	logic clear;
	logic restart;
	logic neglectedAny;
	logic [lifeCountWidth-1:0] lifeCount;
	logic [ageWidth-1:0] age;
	logic [3:0] needy;
	logic [3:0] neglected;
	lifeState state;
	careCmd care;
	petStatus status;

	// the life clock only restarts with the game, it freezes on death
	assign restart = care.valid && care.op == RESTART;
	assign neglectedAny = |neglected;

	lifeTimer #(.ticksPerSecond(ticksPerSecond)) timer (
		.clk(clk), .reset(reset), .clear(restart), .running(running),
		.tick(tick), .lifeCount(lifeCount), .expired(expired)
	);

	for (genvar i = 0; i < 4; i++) begin : needs
		needTracker #(.kind(needKind'(i))) tracker (
			.clk(clk), .reset(reset), .clear(clear), .tick(tick),
			.lifeCount(lifeCount), .needsRunning(needsRunning), .care(care),
			.needy(needy[i]), .neglected(neglected[i])
		);
	end

	petVitality vitality (
		.clk(clk), .reset(reset), .tick(tick), .lifeCount(lifeCount),
		.expired(expired), .neglectedAny(neglectedAny), .care(care),
		.state(state), .age(age), .needsRunning(needsRunning),
		.clear(clear), .running(running)
	);

	assign status = '{
		hungry: needy[HUNGER],
		bored: needy[BOREDOM],
		dirty: needy[DIRTINESS],
		sick: needy[SICKNESS],
		sleeping: state == ASLEEP,
		dying: state == DYING,
		deceased: state == DECEASED,
		age: age,
		lifeCount: lifeCount
	};

	careRegisters regs (
		.clk(clk), .reset(reset), .bus(bus), .busRsp(busRsp),
		.status(status), .care(care)
	);

endmodule

// File: tests/clockGen.sv
module clockGen (
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		reset = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

	always #4 clk = ~clk; // period 8
endmodule

// File: tests/petChecker.sv
module petChecker (
	input logic clk,
	input logic reset,
	input busPkg::axiReq bus,
	input busPkg::axiRsp busRsp,
	input int row,
	input logic [31:0] expData,
	input logic [1:0] expRresp,
	input logic [1:0] expBresp,
	output int checks,
	output int errors
);
	import busPkg::*;

	logic bad;

	// handshakes complete on the rising edge, inputs settle on the falling one
	always @(posedge clk) begin
		if (reset) begin
			checks = 0;
			errors = 0;
		end
		else begin
			if (busRsp.bvalid && bus.bready) begin
				checks = checks + 1;
				if (busRsp.bresp != expBresp) begin
					errors = errors + 1;
					$display("CHECK FAILED row %0d bresp: expected %h, got %h",
						row, expBresp, busRsp.bresp);
				end
			end
			if (busRsp.rvalid && bus.rready) begin
				checks = checks + 1;
				bad = 1'b0;
				if (busRsp.rdata != expData) begin
					bad = 1'b1;
					$display("CHECK FAILED row %0d rdata: expected %h, got %h",
						row, expData, busRsp.rdata);
				end
				if (busRsp.rresp != expRresp) begin
					bad = 1'b1;
					$display("CHECK FAILED row %0d rresp: expected %h, got %h",
						row, expRresp, busRsp.rresp);
				end
				if (bad)
					errors = errors + 1;
				else
					$display("row %0d: read %h, resp %h ok", row, busRsp.rdata, busRsp.rresp);
			end
		end
	end
endmodule

// File: tests/petTb.sv
module petTb;
	import petPkg::*;
	import busPkg::*;

	typedef struct {
		logic doWrite;
		logic [3:0] writeAddr;
		logic [2:0] writeOp;
		logic [1:0] expBresp;
		int ticks; // life seconds to advance before the read
		logic [3:0] readAddr;
		logic [31:0] expData;
		logic [1:0] expRresp;
	} stimRow;

	logic clk;
	logic reset;
	axiReq bus;
	axiRsp busRsp;
	stimRow stimTable[$];
	int cycleNo;
	int origin; // cycle where the life clock last started
	int second;
	int rowIndex;
	int missing;
	int handshakeErrors;
	int writes;
	int checks;
	int errors;
	int limitCycles;
	logic [31:0] expData;
	logic [1:0] expRresp;
	logic [1:0] expBresp;

	clockGen clocks (.clk(clk), .reset(reset));

	petTop #(.ticksPerSecond(4)) dut (.clk(clk), .reset(reset), .bus(bus), .busRsp(busRsp));

	petChecker monitor (
		.clk(clk), .reset(reset), .bus(bus), .busRsp(busRsp), .row(rowIndex),
		.expData(expData), .expRresp(expRresp), .expBresp(expBresp),
		.checks(checks), .errors(errors)
	);

	always @(posedge clk) begin
		if (reset)
			cycleNo <= 0;
		else
			cycleNo <= cycleNo + 1;
	end

	function automatic void addRow(input logic doWrite, input logic [3:0] writeAddr,
			input logic [2:0] writeOp, input logic [1:0] expBresp, input int ticks,
			input logic [3:0] readAddr, input logic [31:0] expData, input logic [1:0] expRresp);
		stimTable.push_back('{doWrite, writeAddr, writeOp, expBresp, ticks, readAddr,
			expData, expRresp});
	endfunction

	task automatic waitCycle(input int target);
		while (cycleNo - origin < target)
			@(negedge clk);
	endtask

	task automatic writeReg(input logic [3:0] addr, input logic [2:0] op);
		int waited;
		waited = 0;
		bus.awvalid = 1'b1;
		bus.awaddr = addr;
		bus.wvalid = 1'b1;
		bus.wdata = {29'd0, op};
		bus.bready = 1'b1;
		while (!(busRsp.awready && busRsp.wready) && waited < 16) begin
			@(negedge clk);
			waited = waited + 1;
		end
		if (!(busRsp.awready && busRsp.wready)) begin
			$display("row %0d: write to %h was never accepted, awready or wready stayed low",
				rowIndex, addr);
			handshakeErrors = handshakeErrors + 1;
		end
		@(negedge clk);
		bus.awvalid = 1'b0;
		bus.wvalid = 1'b0;
		waited = 0;
		while (!busRsp.bvalid && waited < 16) begin
			@(negedge clk);
			waited = waited + 1;
		end
		if (!busRsp.bvalid) begin
			$display("row %0d: write to %h got no write response", rowIndex, addr);
			missing = missing + 1;
		end
		else if (busRsp.awready || busRsp.wready) begin
			$display("row %0d: write ready stayed high while the write response waited",
				rowIndex);
			handshakeErrors = handshakeErrors + 1;
		end
		@(negedge clk);
		bus.bready = 1'b0;
	endtask

	task automatic readReg(input logic [3:0] addr);
		int waited;
		waited = 0;
		bus.arvalid = 1'b1;
		bus.araddr = addr;
		bus.rready = 1'b1;
		while (!busRsp.arready && waited < 16) begin
			@(negedge clk);
			waited = waited + 1;
		end
		if (!busRsp.arready) begin
			$display("row %0d: read of %h was never accepted, arready stayed low",
				rowIndex, addr);
			handshakeErrors = handshakeErrors + 1;
		end
		@(negedge clk);
		bus.arvalid = 1'b0;
		waited = 0;
		while (!busRsp.rvalid && waited < 16) begin
			@(negedge clk);
			waited = waited + 1;
		end
		if (!busRsp.rvalid) begin
			$display("row %0d: read of %h never returned read data", rowIndex, addr);
			missing = missing + 1;
		end
		else if (busRsp.arready) begin
			$display("row %0d: arready stayed high while the read data waited", rowIndex);
			handshakeErrors = handshakeErrors + 1;
		end
		@(negedge clk);
		bus.rready = 1'b0;
	endtask

	initial begin
		int totalTicks;
		bus = '0;
		expData = '0;
		expRresp = '0;
		expBresp = '0;
		origin = 0;
		second = 0;
		rowIndex = 0;
		missing = 0;
		handshakeErrors = 0;
		writes = 0;
		totalTicks = 0;
		limitCycles = 0;
		// after reset
		addRow(0, careAddr, FEED, OKAY, 0, lifeAddr, 32'h0, OKAY);
		addRow(0, careAddr, FEED, OKAY, 1, statusAddr, 32'h0, OKAY);
		addRow(0, careAddr, FEED, OKAY, 1, ageAddr, 32'h0, OKAY);
		addRow(0, careAddr, FEED, OKAY, 1, careAddr, 32'h0, SLVERR);
		addRow(1, ageAddr, FEED, SLVERR, 1, ageAddr, 32'h0, OKAY);
		// hunger and feeding
		addRow(0, careAddr, FEED, OKAY, 11, statusAddr, 32'h1, OKAY);
		addRow(1, careAddr, FEED, OKAY, 1, statusAddr, 32'h0, OKAY);
		addRow(0, careAddr, FEED, OKAY, 1, lifeAddr, 32'd17, OKAY);
		// keep needs answered up to the first sleep at 44
		addRow(0, careAddr, FEED, OKAY, 3, statusAddr, 32'h2, OKAY);
		addRow(1, careAddr, PLAY, OKAY, 5, statusAddr, 32'h4, OKAY);
		addRow(1, careAddr, CLEAN, OKAY, 5, statusAddr, 32'h8, OKAY);
		addRow(1, careAddr, MEDICATE, OKAY, 2, statusAddr, 32'h1, OKAY);
		addRow(1, careAddr, FEED, OKAY, 12, statusAddr, 32'h10, OKAY);
		addRow(0, careAddr, FEED, OKAY, 56, statusAddr, 32'h10, OKAY);
		addRow(0, careAddr, FEED, OKAY, 39, statusAddr, 32'h10, OKAY);
		addRow(0, careAddr, FEED, OKAY, 2, statusAddr, 32'h0, OKAY); // woke at 140
		addRow(0, careAddr, FEED, OKAY, 1, ageAddr, 32'h1, OKAY);
		// hunger from 143 neglected until 170
		addRow(0, careAddr, FEED, OKAY, 27, statusAddr, 32'hf, OKAY);
		addRow(0, careAddr, FEED, OKAY, 2, statusAddr, 32'h20, OKAY);
		addRow(1, careAddr, FIRST_AID, OKAY, 2, statusAddr, 32'h0, OKAY);
		// fresh life, dying at 42, deceased at 252
		addRow(1, careAddr, RESTART, OKAY, 1, ageAddr, 32'h0, OKAY);
		addRow(0, careAddr, FEED, OKAY, 42, statusAddr, 32'h20, OKAY);
		addRow(0, careAddr, FEED, OKAY, 208, statusAddr, 32'h20, OKAY);
		addRow(0, careAddr, FEED, OKAY, 2, statusAddr, 32'h40, OKAY);
		addRow(0, careAddr, FEED, OKAY, 10, lifeAddr, 32'd252, OKAY);
		addRow(1, careAddr, RESTART, OKAY, 0, lifeAddr, 32'h0, OKAY);
		addRow(0, careAddr, FEED, OKAY, 1, statusAddr, 32'h0, OKAY);
		addRow(0, careAddr, FEED, OKAY, 1, ageAddr, 32'h0, OKAY);
		foreach (stimTable[i])
			totalTicks = totalTicks + stimTable[i].ticks + 2;
		limitCycles = totalTicks * 4 + 200;

		@(negedge reset);
		foreach (stimTable[i]) begin
			rowIndex = i;
			if (stimTable[i].doWrite) begin
				waitCycle(4 * second + 3); // accepted on the tick edge, applied mid-second
				expBresp = stimTable[i].expBresp;
				writeReg(stimTable[i].writeAddr, stimTable[i].writeOp);
				writes = writes + 1;
				if (stimTable[i].writeOp == RESTART) begin
					origin = origin + 4 * second + 5;
					second = 0;
				end
			end
			second = second + stimTable[i].ticks;
			waitCycle(4 * second + 1);
			expData = stimTable[i].expData;
			expRresp = stimTable[i].expRresp;
			readReg(stimTable[i].readAddr);
		end

		repeat (4) @(negedge clk);
		$display("%0d checks, %0d errors, %0d missing responses, %0d handshake errors",
			checks, errors, missing, handshakeErrors);
		if (errors == 0 && missing == 0 && handshakeErrors == 0
				&& checks == stimTable.size() + writes) begin
			$display("test passed");
		end
		else begin
			$display("test failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", limitCycles);
		$display("test failed");
		$finish;
	end
endmodule

// File: filelist.f
source/petPkg.sv
source/busPkg.sv
source/lifeTimer.sv
source/needTracker.sv
source/petVitality.sv
source/careRegisters.sv
source/petTop.sv
tests/clockGen.sv
tests/petChecker.sv
tests/petTb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, success only when the pass line shows up
cd "$(dirname "$0")" \
	&& verilator --binary --timing --top-module petTb -f filelist.f -Mdir obj_dir \
	&& ./obj_dir/VpetTb | tee /dev/stderr | grep -qx "test passed" \
	|| { echo "simulation did not pass"; exit 1; }
